//--- tb.f
+incdir+hw
hw/dataPkg.sv
hw/ctrlPkg.sv
hw/instrClassIf.sv
hw/ctrlDecoder.sv
hw/stallUnit.sv
hw/mulDivUnit.sv
hw/decodeStage.sv
sim/decodeStage_sva.sv
sim/decodeStageChecker.sv
sim/decodeStageTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module decodeStageTb --Mdir obj_dir -o simv
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log

grep -q "Simulation PASSED" sim.log

//--- sim/decodeStageTb.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module decodeStageTb import ctrlPkg::*, dataPkg::*; ();
    typedef struct {
        word_t    instr, a, b;
        npcOp_e   npc;
        aluOp_e   alu;
        extOp_e   ext;
        aluBSel_e bsel;
        logic     rfWr, dmWr;
        dmOp_e    dm;
        cmpOp_e   cmp;
        int       stalls;
        logic     mdChk;
        word_t    md;
        mduOp_e   mdu;
        rfWrSel_e wrSel;
        rfWdSel_e wdSel;
        logic     sExt;
        regAddr_t dest;
    } row_t;

    localparam int Period = 4;

    logic clk = 1'b0;
    logic rstN, rowActive, tableReady;
    word_t instr, rsVal, rtVal;
    row_t rows[$];
    row_t cur;
    int rowIdx, errCount, rowsDone;
    longint limitNs;

    logic stall, rfWrEn, dmWrEn, dmSignExt, eRfWrEn, mdBusy;
    npcOp_e npcOp;
    aluOp_e aluOp, eAluOp;
    extOp_e extOp;
    mduOp_e mduOp, eMduOp;
    rfWrSel_e rfWrSel;
    rfWdSel_e rfWdSel;
    aluBSel_e aluBSel;
    cmpOp_e cmpOp;
    dmOp_e dmOp;
    regAddr_t eDest;
    word_t mdOut;

    decodeStage dut (.*);

    decodeStageChecker chk (
        .clk, .rowActive, .rowIdx, .stall, .npcOp, .aluOp, .extOp, .mduOp, .aluBSel,
        .rfWrEn, .rfWrSel, .rfWdSel, .dmWrEn, .dmOp, .dmSignExt, .cmpOp, .eAluOp,
        .eMduOp, .eRfWrEn, .eDest, .mdOut, .expNpc(cur.npc), .expAlu(cur.alu),
        .expExt(cur.ext), .expMdu(cur.mdu), .expBSel(cur.bsel), .expRfWrEn(cur.rfWr),
        .expWrSel(cur.wrSel), .expWdSel(cur.wdSel), .expDmWrEn(cur.dmWr),
        .expDmOp(cur.dm), .expSExt(cur.sExt), .expCmp(cur.cmp), .expDest(cur.dest),
        .expStalls(cur.stalls), .expMdChk(cur.mdChk), .expMd(cur.md), .errCount,
        .rowsDone
    );

    initial begin
        forever #(Period / 2) clk = ~clk;
    end

    function automatic word_t rType(funct_t fn, int rs, int rt, int rd);
        return {`OP_SPECIAL, 5'(rs), 5'(rt), 5'(rd), 5'b0, fn};
    endfunction

    function automatic word_t iType(opcode_t op, int rs, int rt, int imm);
        return {op, 5'(rs), 5'(rt), 16'(imm)};
    endfunction

    task automatic addRow(word_t ins, word_t a, word_t b, npcOp_e npc, aluOp_e alu,
                          extOp_e ext, aluBSel_e bsel, logic rfWr, logic dmWr,
                          dmOp_e dm, cmpOp_e cmp, int stalls);
        row_t r;
        r = '{ins, a, b, npc, alu, ext, bsel, rfWr, dmWr, dm, cmp, stalls, 1'b0, '0,
              MDU_NONE, WRSEL_RT, WDSEL_EU, 1'b0, '0};
        rows.push_back(r);
    endtask

    // Attach an expected mdOut to the most recent row
    task automatic expectMd(word_t v);
        rows[rows.size() - 1].mdChk = 1'b1;
        rows[rows.size() - 1].md    = v;
    endtask

    // Write-back selection and destination register of the most recent row
    task automatic markWrite(rfWrSel_e sel, rfWdSel_e wd, int dest);
        rows[rows.size() - 1].wrSel = sel;
        rows[rows.size() - 1].wdSel = wd;
        rows[rows.size() - 1].dest  = regAddr_t'(dest);
    endtask

    // Plain calculation row with no memory, branch or ALU immediate
    task automatic addCalc(word_t ins, aluOp_e alu, mduOp_e mdu, logic rfWr, int dest,
                           int stalls);
        addRow(ins, '0, '0, NPC_PC4, alu, EXT_ZERO, BSEL_RT, rfWr, 1'b0, DM_NONE,
               CMP_NONE, stalls);
        rows[rows.size() - 1].mdu = mdu;
        // Register-type writers target rd
        if (rfWr) begin
            markWrite(WRSEL_RD, WDSEL_EU, dest);
        end
    endtask

    task automatic buildTable();
        longint prod, acc;
        int quot, rem;
        // Decode of each ALU class
        addCalc(rType(`FN_ADDU, 1, 2, 3), ALU_ADD, MDU_NONE, 1, 3, 0);
        addCalc(rType(`FN_SUB, 3, 2, 4), ALU_SUB, MDU_NONE, 1, 4, 0);
        addCalc(rType(`FN_AND, 1, 2, 5), ALU_AND, MDU_NONE, 1, 5, 0);
        addCalc(rType(`FN_OR, 1, 2, 6), ALU_OR, MDU_NONE, 1, 6, 0);
        addCalc(rType(`FN_SLT, 1, 2, 7), ALU_SLT, MDU_NONE, 1, 7, 0);
        addCalc(rType(`FN_SLTU, 1, 2, 8), ALU_SLTU, MDU_NONE, 1, 8, 0);
        addRow(iType(`OP_ADDI, 1, 9, 5), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 1, 0,
               DM_NONE, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_EU, 9);
        addRow(iType(`OP_ANDI, 1, 10, 255), 0, 0, NPC_PC4, ALU_AND, EXT_ZERO, BSEL_IMM, 1, 0,
               DM_NONE, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_EU, 10);
        addRow(iType(`OP_ORI, 1, 11, 1), 0, 0, NPC_PC4, ALU_OR, EXT_ZERO, BSEL_IMM, 1, 0,
               DM_NONE, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_EU, 11);
        addRow(iType(`OP_LUI, 0, 12, 16'h1234), 0, 0, NPC_PC4, ALU_ADD, EXT_LUI, BSEL_IMM, 1,
               0, DM_NONE, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_EU, 12);
        addRow(iType(`OP_SW, 1, 2, 4), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 0, 1,
               DM_W, CMP_NONE, 0);
        addRow(iType(`OP_SH, 1, 2, 4), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 0, 1,
               DM_H, CMP_NONE, 0);
        addRow(iType(`OP_SB, 1, 2, 4), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 0, 1,
               DM_B, CMP_NONE, 0);
        ////////////////////
        // Load-use hazards
        ////////////////////
        addRow(iType(`OP_LW, 1, 13, 0), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 1, 0,
               DM_W, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_DMRD, 13);
        addCalc(rType(`FN_ADD, 13, 1, 14), ALU_ADD, MDU_NONE, 1, 14, 1);
        addRow(iType(`OP_LH, 1, 15, 0), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 1, 0,
               DM_H, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_DMRD, 15);
        rows[rows.size() - 1].sExt = 1'b1;
        addCalc(rType(`FN_ADD, 1, 2, 16), ALU_ADD, MDU_NONE, 1, 16, 0);
        // Load into register 0 never creates a hazard
        addRow(iType(`OP_LB, 1, 0, 0), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 1, 0,
               DM_B, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_DMRD, 0);
        rows[rows.size() - 1].sExt = 1'b1;
        addCalc(rType(`FN_ADD, 0, 1, 17), ALU_ADD, MDU_NONE, 1, 17, 0);
        ////////////////////
        // Branch and jump hazards
        ////////////////////
        addRow(iType(`OP_BEQ, 17, 1, 4), 0, 0, NPC_BR, ALU_ADD, EXT_ZERO, BSEL_RT, 0, 0,
               DM_NONE, CMP_BEQ, 1);
        addRow(iType(`OP_LW, 1, 18, 0), 0, 0, NPC_PC4, ALU_ADD, EXT_SIGN, BSEL_IMM, 1, 0,
               DM_W, CMP_NONE, 0);
        markWrite(WRSEL_RT, WDSEL_DMRD, 18);
        addRow(iType(`OP_BNE, 18, 2, 4), 0, 0, NPC_BR, ALU_ADD, EXT_ZERO, BSEL_RT, 0, 0,
               DM_NONE, CMP_BNE, 2);
        addRow({`OP_JAL, 26'h10}, 0, 0, NPC_JL, ALU_ADD, EXT_ZERO, BSEL_RT, 1, 0, DM_NONE,
               CMP_NONE, 0);
        markWrite(WRSEL_R31, WDSEL_PC8, 31);
        addRow(rType(`FN_JR, 31, 0, 0), 0, 0, NPC_JR, ALU_ADD, EXT_ZERO, BSEL_RT, 0, 0,
               DM_NONE, CMP_NONE, 1);
        ////////////////////
        // Multiply and divide
        ////////////////////
        prod = longint'($signed(32'hfffffff9)) * longint'(12);
        addCalc(rType(`FN_MULT, 1, 2, 0), ALU_ADD, MDU_MULT, 0, 0, 0);
        rows[rows.size() - 1].a = 32'hfffffff9;
        rows[rows.size() - 1].b = 12;
        addCalc(rType(`FN_MFHI, 0, 0, 19), ALU_ADD, MDU_MFHI, 1, 19, `MULT_CYCLES + 1);
        expectMd(prod[63:32]);
        addCalc(rType(`FN_MFLO, 0, 0, 20), ALU_ADD, MDU_MFLO, 1, 20, 0);
        expectMd(prod[31:0]);
        quot = -100 / 7;
        rem  = -100 % 7;
        addRow(rType(`FN_DIV, 1, 2, 0), -100, 7, NPC_PC4, ALU_ADD, EXT_ZERO, BSEL_RT, 0, 0,
               DM_NONE, CMP_NONE, 0);
        rows[rows.size() - 1].mdu = MDU_DIV;
        addCalc(rType(`FN_MFLO, 0, 0, 20), ALU_ADD, MDU_MFLO, 1, 20, `DIV_CYCLES + 1);
        expectMd(quot);
        addCalc(rType(`FN_MFHI, 0, 0, 19), ALU_ADD, MDU_MFHI, 1, 19, 0);
        expectMd(rem);
        // madd accumulates onto the remainder and quotient left by div
        acc = longint'({rem, quot}) + longint'(3) * longint'(-5);
        addRow({`OP_SPECIAL2, 5'd1, 5'd2, 10'b0, `FN_MADD}, 3, -5, NPC_PC4, ALU_ADD,
               EXT_ZERO, BSEL_RT, 0, 0, DM_NONE, CMP_NONE, 0);
        rows[rows.size() - 1].mdu = MDU_MADD;
        addCalc(rType(`FN_MFHI, 0, 0, 19), ALU_ADD, MDU_MFHI, 1, 19, `MULT_CYCLES + 1);
        expectMd(acc[63:32]);
        addCalc(rType(`FN_MFLO, 0, 0, 20), ALU_ADD, MDU_MFLO, 1, 20, 0);
        expectMd(acc[31:0]);
        // Moves into hi and lo, then a divide by zero that must not touch them
        addCalc(rType(`FN_MTHI, 1, 0, 0), ALU_ADD, MDU_MTHI, 0, 0, 0);
        rows[rows.size() - 1].a = 32'hcafe0001;
        addCalc(rType(`FN_MTLO, 1, 0, 0), ALU_ADD, MDU_MTLO, 0, 0, 0);
        rows[rows.size() - 1].a = 32'h0000beef;
        addCalc(rType(`FN_MFHI, 0, 0, 19), ALU_ADD, MDU_MFHI, 1, 19, 0);
        expectMd(32'hcafe0001);
        addCalc(rType(`FN_MFLO, 0, 0, 20), ALU_ADD, MDU_MFLO, 1, 20, 0);
        expectMd(32'h0000beef);
        addRow(rType(`FN_DIVU, 1, 2, 0), 5, 0, NPC_PC4, ALU_ADD, EXT_ZERO, BSEL_RT, 0, 0,
               DM_NONE, CMP_NONE, 0);
        rows[rows.size() - 1].mdu = MDU_DIVU;
        addCalc(rType(`FN_MFHI, 0, 0, 19), ALU_ADD, MDU_MFHI, 1, 19, `DIV_CYCLES + 1);
        expectMd(32'hcafe0001);
        addCalc(rType(`FN_MFLO, 0, 0, 20), ALU_ADD, MDU_MFLO, 1, 20, 0);
        expectMd(32'h0000beef);
        prod = longint'(32'hffff0001) * longint'(32'h10);
        addRow(rType(`FN_MULTU, 1, 2, 0), 32'hffff0001, 32'h10, NPC_PC4, ALU_ADD, EXT_ZERO,
               BSEL_RT, 0, 0, DM_NONE, CMP_NONE, 0);
        rows[rows.size() - 1].mdu = MDU_MULTU;
        addCalc(rType(`FN_MFLO, 0, 0, 20), ALU_ADD, MDU_MFLO, 1, 20, `MULT_CYCLES + 1);
        expectMd(prod[31:0]);
        // Unknown opcode decodes to a no-operation
        addCalc(32'hfc000000, ALU_ADD, MDU_NONE, 0, 0, 0);
    endtask

    initial begin
        rstN       = 1'b0;
        rowActive  = 1'b0;
        tableReady = 1'b0;
        instr      = '0;
        rsVal      = '0;
        rtVal      = '0;
        rowIdx     = 0;
        buildTable();
        cur = rows[0];
        limitNs = 10;
        foreach (rows[i]) begin
            limitNs += 1 + rows[i].stalls;
        end
        limitNs = (limitNs + `DIV_CYCLES) * Period * 2;
        tableReady = 1'b1;
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);
        foreach (rows[i]) begin
            instr     <= rows[i].instr;
            cur       <= rows[i];
            rowIdx    <= i;
            rowActive <= 1'b1;
            // instr stays put until the DUT accepts it
            @(negedge clk);
            while (stall) @(negedge clk);
            @(posedge clk);
            rsVal <= rows[i].a;
            rtVal <= rows[i].b;
        end
        rowActive <= 1'b0;
        repeat (3) @(posedge clk);
        $display("Rows checked %0d of %0d, errors %0d", rowsDone, rows.size(), errCount);
        if (rowsDone != rows.size()) begin
            $display("Not every row of the table was checked");
        end
        if (errCount == 0 && rowsDone == rows.size()) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (tableReady);
        #(limitNs);
        $display("Watchdog expired after %0d ns, the DUT stopped making progress", limitNs);
        $display("Simulation FAILED");
        $finish;
    end
endmodule

//--- sim/decodeStageChecker.sv
`timescale 1ns/1ns

module decodeStageChecker import ctrlPkg::*, dataPkg::*; (
    input  logic     clk,
    input  logic     rowActive,
    input  int       rowIdx,
    // DUT outputs
    input  logic     stall,
    input  npcOp_e   npcOp,
    input  aluOp_e   aluOp,
    input  extOp_e   extOp,
    input  mduOp_e   mduOp,
    input  aluBSel_e aluBSel,
    input  logic     rfWrEn,
    input  rfWrSel_e rfWrSel,
    input  rfWdSel_e rfWdSel,
    input  logic     dmWrEn,
    input  dmOp_e    dmOp,
    input  logic     dmSignExt,
    input  cmpOp_e   cmpOp,
    input  aluOp_e   eAluOp,
    input  mduOp_e   eMduOp,
    input  logic     eRfWrEn,
    input  regAddr_t eDest,
    input  word_t    mdOut,
    // Expected values of the current row
    input  npcOp_e   expNpc,
    input  aluOp_e   expAlu,
    input  extOp_e   expExt,
    input  mduOp_e   expMdu,
    input  aluBSel_e expBSel,
    input  logic     expRfWrEn,
    input  rfWrSel_e expWrSel,
    input  rfWdSel_e expWdSel,
    input  logic     expDmWrEn,
    input  dmOp_e    expDmOp,
    input  logic     expSExt,
    input  cmpOp_e   expCmp,
    input  regAddr_t expDest,
    input  int       expStalls,
    input  logic     expMdChk,
    input  word_t    expMd,
    output int       errCount,
    output int       rowsDone
);
    int       stallCnt = 0;
    int       rowErr = 0;
    logic     pending = 1'b0;
    int       pendRow;
    int       pendStalls;
    logic     pendMdChk;
    word_t    pendMd;
    aluOp_e   pendAlu;
    mduOp_e   pendMdu;
    logic     pendRfWr;
    regAddr_t pendDest;

    initial begin
        errCount = 0;
        rowsDone = 0;
    end

    task automatic compare(string name, longint unsigned expV, longint unsigned actV);
        if (expV !== actV) begin
            $display("FAILED t=%0t %s expected %0h got %0h", $time, name, expV, actV);
            errCount++;
            rowErr++;
        end
    endtask

    // Sample mid-cycle, where every output has settled
    always @(negedge clk) begin
        // Execute-stage outputs of an accepted row show up one cycle later
        if (pending) begin
            compare("eAluOp", pendAlu, eAluOp);
            compare("eMduOp", pendMdu, eMduOp);
            compare("eRfWrEn", pendRfWr, eRfWrEn);
            if (pendRfWr) begin
                compare("eDest", pendDest, eDest);
            end
            if (pendMdChk) begin
                compare("mdOut", pendMd, mdOut);
            end
            $display("Row %0d: %s, %0d stall cycles", pendRow,
                     rowErr == 0 ? "pass" : "mismatch", pendStalls);
            rowsDone++;
            rowErr  = 0;
            pending = 1'b0;
        end
        if (rowActive) begin
            if (stall) begin
                stallCnt++;
            end else begin
                compare("npcOp", expNpc, npcOp);
                compare("aluOp", expAlu, aluOp);
                compare("extOp", expExt, extOp);
                compare("mduOp", expMdu, mduOp);
                compare("aluBSel", expBSel, aluBSel);
                compare("rfWrEn", expRfWrEn, rfWrEn);
                compare("rfWrSel", expWrSel, rfWrSel);
                compare("rfWdSel", expWdSel, rfWdSel);
                compare("dmWrEn", expDmWrEn, dmWrEn);
                compare("dmOp", expDmOp, dmOp);
                compare("dmSignExt", expSExt, dmSignExt);
                compare("cmpOp", expCmp, cmpOp);
                compare("stall cycles", expStalls, stallCnt);
                pending    = 1'b1;
                pendRow    = rowIdx;
                pendStalls = stallCnt;
                pendMdChk  = expMdChk;
                pendMd     = expMd;
                pendAlu    = expAlu;
                pendMdu    = expMdu;
                pendRfWr   = expRfWrEn;
                pendDest   = expDest;
                stallCnt   = 0;
            end
        end
    end
endmodule

//--- sim/decodeStage_sva.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module decodeStage_sva import ctrlPkg::*; (
    input logic   clk,
    input logic   rstN,
    input logic   stall,
    input logic   mdBusy,
    input logic   eRfWrEn,
    input mduOp_e eMduOp
);
    int busyLen;
    int expLen;

    // Length of the current busy run, and the latency the starting op asks for
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busyLen <= 0;
            expLen  <= 0;
        end else if (mdBusy) begin
            busyLen <= busyLen + 1;
        end else begin
            busyLen <= 0;
            expLen  <= (eMduOp == MDU_DIV || eMduOp == MDU_DIVU) ? `DIV_CYCLES : `MULT_CYCLES;
        end
    end

    noStallInReset: assert property (@(posedge clk) !rstN |-> !stall)
        else $error("stall high during reset");

    busyLength: assert property (@(posedge clk) disable iff (!rstN)
        $fell(mdBusy) |-> busyLen == expLen)
        else $error("mdBusy lasted %0d cycles, expected %0d", busyLen, expLen);

    bubbleAfterStall: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> !eRfWrEn)
        else $error("no bubble in exec after a stalled cycle");
endmodule

bind decodeStage decodeStage_sva sva (
    .clk, .rstN, .stall, .mdBusy, .eRfWrEn, .eMduOp
);

//--- hw/decodeStage.sv
`timescale 1ns/1ns

module decodeStage import ctrlPkg::*, dataPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    input  word_t    instr,
    input  word_t    rsVal,
    input  word_t    rtVal,
    output logic     stall,
    // Decode stage
    output npcOp_e   npcOp,
    output aluOp_e   aluOp,
    output extOp_e   extOp,
    output mduOp_e   mduOp,
    output logic     rfWrEn,
    output rfWrSel_e rfWrSel,
    output rfWdSel_e rfWdSel,
    output aluBSel_e aluBSel,
    output cmpOp_e   cmpOp,
    output logic     dmWrEn,
    output dmOp_e    dmOp,
    output logic     dmSignExt,
    // Execute stage
    output aluOp_e   eAluOp,
    output mduOp_e   eMduOp,
    output logic     eRfWrEn,
    output regAddr_t eDest,
    output logic     mdBusy,
    output word_t    mdOut
);
    instrClassIf cls ();
    logic eMdStart;

    ctrlDecoder decoder (
        .instr, .npcOp, .aluOp, .extOp, .mduOp, .rfWrEn, .rfWrSel, .rfWdSel,
        .aluBSel, .cmpOp, .dmWrEn, .dmOp, .dmSignExt, .cls(cls.decoder)
    );

    stallUnit hazard (
        .clk, .rstN, .cls(cls.stall), .mduOp, .aluOp, .rfWrEn, .mdBusy,
        .stall, .eMdStart, .eMduOp, .eAluOp, .eRfWrEn, .eDest
    );

    mulDivUnit mdu (
        .clk, .rstN, .start(eMdStart), .op(eMduOp), .a(rsVal), .b(rtVal),
        .busy(mdBusy), .out(mdOut)
    );
endmodule

//--- hw/mulDivUnit.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module mulDivUnit import ctrlPkg::*, dataPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  logic   start,
    input  mduOp_e op,
    input  word_t  a,
    input  word_t  b,
    output logic   busy,
    output word_t  out
);
    localparam int CntW = $clog2(`DIV_CYCLES + 1);

    logic [CntW-1:0] count;
    word_t hi, lo, resHi, resLo, divisor;
    logic isDiv, divByZero, commitPend;
    logic signed [63:0] sProd;
    logic [63:0] uProd, accSum;

    assign isDiv     = (op == MDU_DIV) || (op == MDU_DIVU);
    assign divByZero = (b == '0);
    // Keeps the divider away from a zero operand
    assign divisor   = divByZero ? word_t'(1) : b;

    assign sProd  = $signed(a) * $signed(b);
    assign uProd  = {32'b0, a} * {32'b0, b};
    assign accSum = {hi, lo} + sProd;

    ////////////////////
    // Result computed at start
    ////////////////////
    always_ff @(posedge clk) begin
        if (start) begin
            case (op)
                MDU_MULT:  {resHi, resLo} <= sProd;
                MDU_MULTU: {resHi, resLo} <= uProd;
                MDU_MADD:  {resHi, resLo} <= accSum;
                MDU_DIV: begin
                    resLo <= $signed(a) / $signed(divisor);
                    resHi <= $signed(a) % $signed(divisor);
                end
                MDU_DIVU: begin
                    resLo <= a / divisor;
                    resHi <= a % divisor;
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // Latency counter and hi/lo
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            busy       <= 1'b0;
            count      <= '0;
            commitPend <= 1'b0;
            hi         <= '0;
            lo         <= '0;
        end else begin
            if (start) begin
                busy       <= 1'b1;
                count      <= isDiv ? CntW'(`DIV_CYCLES - 1) : CntW'(`MULT_CYCLES - 1);
                commitPend <= !(isDiv && divByZero);
            end else if (busy) begin
                if (count == '0) begin
                    busy <= 1'b0;
                    // Commit on the edge where busy falls
                    if (commitPend) begin
                        hi <= resHi;
                        lo <= resLo;
                    end
                end else begin
                    count <= count - 1'b1;
                end
            end
            if (op == MDU_MTHI) begin
                hi <= a;
            end
            if (op == MDU_MTLO) begin
                lo <= a;
            end
        end
    end

    assign out = (op == MDU_MFHI) ? hi : (op == MDU_MFLO) ? lo : '0;
endmodule

//--- hw/stallUnit.sv
`timescale 1ns/1ns

module stallUnit import ctrlPkg::*, dataPkg::*; (
    input  logic     clk,
    input  logic     rstN,
    instrClassIf.stall cls,
    input  mduOp_e   mduOp,
    input  aluOp_e   aluOp,
    input  logic     rfWrEn,
    input  logic     mdBusy,
    output logic     stall,
    output logic     eMdStart,
    output mduOp_e   eMduOp,
    output aluOp_e   eAluOp,
    output logic     eRfWrEn,
    output regAddr_t eDest
);
    stageInfo_t decInfo, exec, mem;
    logic decValid, needsCmp, needsMdu;
    logic loadUse, cmpOnExec, cmpOnMemLoad, mduHold;

    // True when stage s will write register r
    function automatic logic hits(stageInfo_t s, regAddr_t r);
        return s.writes && (s.dest != '0) && (s.dest == r);
    endfunction

    function automatic logic readsFrom(stageInfo_t s, logic rdRs, logic rdRt,
                                       regAddr_t rs, regAddr_t rt);
        return (rdRs && hits(s, rs)) || (rdRt && hits(s, rt));
    endfunction

    // Anything unrecognized enters exec as a bubble
    assign decValid = cls.calcR || cls.calcI || cls.lui || cls.md || cls.mt || cls.mf ||
                      cls.madd || cls.load || cls.store || cls.branch || cls.jal || cls.jr;

    assign decInfo.writes  = decValid && cls.writes;
    assign decInfo.dest    = cls.dest;
    assign decInfo.isLoad  = cls.load;
    assign decInfo.mdStart = cls.md || cls.madd;

    ////////////////////
    // Hazard detection
    ////////////////////
    assign needsCmp = cls.branch || cls.jr;
    assign needsMdu = cls.md || cls.mt || cls.mf || cls.madd;

    assign loadUse      = exec.isLoad &&
                          readsFrom(exec, cls.readsRs, cls.readsRt, cls.rs, cls.rt);
    assign cmpOnExec    = needsCmp &&
                          readsFrom(exec, cls.readsRs, cls.readsRt, cls.rs, cls.rt);
    assign cmpOnMemLoad = needsCmp && mem.isLoad &&
                          readsFrom(mem, cls.readsRs, cls.readsRt, cls.rs, cls.rt);
    assign mduHold      = needsMdu && (mdBusy || exec.mdStart);

    assign stall = loadUse || cmpOnExec || cmpOnMemLoad || mduHold;

    ////////////////////
    // Exec and mem registers
    ////////////////////
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exec    <= '0;
            mem     <= '0;
            eMduOp  <= MDU_NONE;
            eAluOp  <= ALU_ADD;
            eRfWrEn <= 1'b0;
        end else begin
            // mem always advances, stall only blocks decode
            mem <= exec;
            if (stall) begin
                exec    <= '0;
                eMduOp  <= MDU_NONE;
                eAluOp  <= ALU_ADD;
                eRfWrEn <= 1'b0;
            end else begin
                exec    <= decInfo;
                eMduOp  <= decValid ? mduOp : MDU_NONE;
                eAluOp  <= aluOp;
                eRfWrEn <= rfWrEn;
            end
        end
    end

    assign eMdStart = exec.mdStart;
    assign eDest    = exec.dest;
endmodule

//--- hw/ctrlDecoder.sv
`timescale 1ns/1ns
`include "mips_consts.svh"

module ctrlDecoder import ctrlPkg::*, dataPkg::*; (
    input  word_t    instr,
    output npcOp_e   npcOp,
    output aluOp_e   aluOp,
    output extOp_e   extOp,
    output mduOp_e   mduOp,
    output logic     rfWrEn,
    output rfWrSel_e rfWrSel,
    output rfWdSel_e rfWdSel,
    output aluBSel_e aluBSel,
    output cmpOp_e   cmpOp,
    output logic     dmWrEn,
    output dmOp_e    dmOp,
    output logic     dmSignExt,
    instrClassIf.decoder cls
);
    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rd;
    logic     special;

    logic isAdd, isAddu, isSub, isAnd, isOr, isSlt, isSltu, isLui;
    logic isAddi, isAndi, isOri;
    logic isLb, isLh, isLw, isSb, isSh, isSw;
    logic isMult, isMultu, isDiv, isDivu, isMfhi, isMflo, isMthi, isMtlo, isMadd;
    logic isBeq, isBne, isJal, isJr;

    assign opcode  = instr[31:26];
    assign funct   = instr[5:0];
    assign rd      = instr[15:11];
    assign special = (opcode == `OP_SPECIAL);

    ////////////////////
    // Instruction strobes
    ////////////////////
    assign isAdd   = special && funct == `FN_ADD;
    assign isAddu  = special && funct == `FN_ADDU;
    assign isSub   = special && funct == `FN_SUB;
    assign isAnd   = special && funct == `FN_AND;
    assign isOr    = special && funct == `FN_OR;
    assign isSlt   = special && funct == `FN_SLT;
    assign isSltu  = special && funct == `FN_SLTU;
    assign isMult  = special && funct == `FN_MULT;
    assign isMultu = special && funct == `FN_MULTU;
    assign isDiv   = special && funct == `FN_DIV;
    assign isDivu  = special && funct == `FN_DIVU;
    assign isMfhi  = special && funct == `FN_MFHI;
    assign isMflo  = special && funct == `FN_MFLO;
    assign isMthi  = special && funct == `FN_MTHI;
    assign isMtlo  = special && funct == `FN_MTLO;
    assign isJr    = special && funct == `FN_JR;
    assign isMadd  = opcode == `OP_SPECIAL2 && funct == `FN_MADD;

    assign isLui  = opcode == `OP_LUI;
    assign isAddi = opcode == `OP_ADDI;
    assign isAndi = opcode == `OP_ANDI;
    assign isOri  = opcode == `OP_ORI;
    assign isLb   = opcode == `OP_LB;
    assign isLh   = opcode == `OP_LH;
    assign isLw   = opcode == `OP_LW;
    assign isSb   = opcode == `OP_SB;
    assign isSh   = opcode == `OP_SH;
    assign isSw   = opcode == `OP_SW;
    assign isBeq  = opcode == `OP_BEQ;
    assign isBne  = opcode == `OP_BNE;
    assign isJal  = opcode == `OP_JAL;

    ////////////////////
    // Class flags
    ////////////////////
    assign cls.calcR  = isAdd || isAddu || isSub || isAnd || isOr || isSlt || isSltu;
    assign cls.calcI  = isAddi || isAndi || isOri;
    assign cls.lui    = isLui;
    assign cls.md     = isMult || isMultu || isDiv || isDivu;
    assign cls.mt     = isMthi || isMtlo;
    assign cls.mf     = isMfhi || isMflo;
    assign cls.madd   = isMadd;
    assign cls.load   = isLb || isLh || isLw;
    assign cls.store  = isSb || isSh || isSw;
    assign cls.branch = isBeq || isBne;
    assign cls.jal    = isJal;
    assign cls.jr     = isJr;

    ////////////////////
    // Control fields, first match wins
    ////////////////////
    assign npcOp = cls.branch ? NPC_BR : isJal ? NPC_JL : isJr ? NPC_JR : NPC_PC4;

    assign rfWrEn = cls.calcR || cls.calcI || isLui || cls.mf || cls.load || isJal;

    assign rfWrSel = (cls.calcI || isLui || cls.load) ? WRSEL_RT :
                     (cls.calcR || cls.mf)            ? WRSEL_RD :
                     isJal                            ? WRSEL_R31 : WRSEL_RT;

    assign rfWdSel = cls.load ? WDSEL_DMRD : isJal ? WDSEL_PC8 : WDSEL_EU;

    assign extOp = (cls.load || cls.store || isAddi) ? EXT_SIGN :
                   isLui                             ? EXT_LUI  : EXT_ZERO;

    assign mduOp = isMult  ? MDU_MULT  :
                   isMultu ? MDU_MULTU :
                   isDiv   ? MDU_DIV   :
                   isDivu  ? MDU_DIVU  :
                   isMfhi  ? MDU_MFHI  :
                   isMflo  ? MDU_MFLO  :
                   isMthi  ? MDU_MTHI  :
                   isMtlo  ? MDU_MTLO  :
                   isMadd  ? MDU_MADD  : MDU_NONE;

    assign aluOp = isSub            ? ALU_SUB  :
                   (isOr || isOri)   ? ALU_OR   :
                   (isAnd || isAndi) ? ALU_AND  :
                   isSlt            ? ALU_SLT  :
                   isSltu           ? ALU_SLTU : ALU_ADD;

    assign aluBSel = (cls.calcI || isLui || cls.load || cls.store) ? BSEL_IMM : BSEL_RT;

    assign cmpOp = isBeq ? CMP_BEQ : isBne ? CMP_BNE : CMP_NONE;

    assign dmWrEn    = cls.store;
    assign dmOp      = (isLw || isSw) ? DM_W : (isLh || isSh) ? DM_H :
                       (isLb || isSb) ? DM_B : DM_NONE;
    assign dmSignExt = isLb || isLh;

    ////////////////////
    // Register usage for hazard checks
    ////////////////////
    assign cls.rs = instr[25:21];
    assign cls.rt = instr[20:16];

    assign cls.readsRs = cls.calcR || cls.calcI || cls.load || cls.store || cls.branch ||
                         isJr || cls.md || cls.mt || isMadd;
    assign cls.readsRt = cls.calcR || cls.store || cls.branch || cls.md || isMadd;

    // Zero when nothing is written, so a stale field never matches
    assign cls.dest = !rfWrEn              ? '0           :
                      rfWrSel == WRSEL_RD  ? rd           :
                      rfWrSel == WRSEL_R31 ? regAddr_t'(31) : cls.rt;
    assign cls.writes = rfWrEn && (cls.dest != '0);
endmodule

//--- hw/instrClassIf.sv
`timescale 1ns/1ns

interface instrClassIf import dataPkg::*; ();
    // Instruction class
    logic calcR, calcI, lui, md, mt, mf, madd;
    logic load, store, branch, jal, jr;

    // Register usage
    logic     readsRs, readsRt;
    regAddr_t rs, rt, dest;
    logic     writes;

    modport decoder (
        output calcR, calcI, lui, md, mt, mf, madd, load, store, branch, jal, jr,
        output readsRs, readsRt, rs, rt, dest, writes
    );

    modport stall (
        input calcR, calcI, lui, md, mt, mf, madd, load, store, branch, jal, jr,
        input readsRs, readsRt, rs, rt, dest, writes
    );
endinterface

//--- hw/ctrlPkg.sv
package ctrlPkg;
    import dataPkg::*;

    typedef enum logic [1:0] {NPC_PC4, NPC_BR, NPC_JL, NPC_JR} npcOp_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU
    } aluOp_e;

    typedef enum logic [1:0] {EXT_ZERO, EXT_SIGN, EXT_LUI} extOp_e;

    typedef enum logic [3:0] {
        MDU_NONE, MDU_MULT, MDU_MULTU, MDU_DIV, MDU_DIVU,
        MDU_MFHI, MDU_MFLO, MDU_MTHI, MDU_MTLO, MDU_MADD
    } mduOp_e;

    typedef enum logic [1:0] {WRSEL_RT, WRSEL_RD, WRSEL_R31} rfWrSel_e;

    typedef enum logic [1:0] {WDSEL_EU, WDSEL_DMRD, WDSEL_PC8} rfWdSel_e;

    typedef enum logic {BSEL_RT, BSEL_IMM} aluBSel_e;

    typedef enum logic [1:0] {CMP_NONE, CMP_BEQ, CMP_BNE} cmpOp_e;

    typedef enum logic [1:0] {DM_NONE, DM_W, DM_H, DM_B} dmOp_e;

    // One in-flight instruction as seen by the hazard logic
    typedef struct packed {
        logic     writes;
        regAddr_t dest;
        logic     isLoad;
        logic     mdStart;
    } stageInfo_t;

endpackage

//--- hw/dataPkg.sv
package dataPkg;

    typedef logic [31:0] word_t;

    typedef logic [4:0] regAddr_t;

    // Instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;

endpackage

//--- hw/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

// Primary opcodes
`define OP_SPECIAL  6'b000000
`define OP_SPECIAL2 6'b011100
`define OP_LUI      6'b001111
`define OP_ADDI     6'b001000
`define OP_ANDI     6'b001100
`define OP_ORI      6'b001101
`define OP_LB       6'b100000
`define OP_LH       6'b100001
`define OP_LW       6'b100011
`define OP_SB       6'b101000
`define OP_SH       6'b101001
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_BNE      6'b000101
`define OP_JAL      6'b000011

// Function codes under OP_SPECIAL
`define FN_ADD      6'b100000
`define FN_ADDU     6'b100001
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010
`define FN_SLTU     6'b101011
`define FN_MULT     6'b011000
`define FN_MULTU    6'b011001
`define FN_DIV      6'b011010
`define FN_DIVU     6'b011011
`define FN_MFHI     6'b010000
`define FN_MFLO     6'b010010
`define FN_MTHI     6'b010001
`define FN_MTLO     6'b010011
`define FN_JR       6'b001000
// madd lives under OP_SPECIAL2
`define FN_MADD     6'b000000

// Busy length of the multiply/divide unit, in cycles
`define MULT_CYCLES 5
`define DIV_CYCLES  10

`endif
